//--- list.f
verilog/vga_pkg.sv
verilog/dla_pkg.sv
verilog/dla_vram_init.sv
verilog/vram_write_fifo.sv
verilog/dla_vram.sv
verilog/dla_init_subsys.sv
verif/dla_init_checker.sv
verif/tb_dla_init.sv

//--- run.sh
#!/usr/bin/env bash
# build the DLA init testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary -f list.f --top-module tb_dla_init --Mdir obj_dir -o sim_dla_init &&
./obj_dir/sim_dla_init | tee /dev/stderr | grep -qF "Testbench passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

//--- verif/tb_dla_init.sv
// --------------------------------------------------------------------
// testbench for the DLA init subsystem that runs inits with random read
// traffic and compares full readbacks against a frame model
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_dla_init;

    localparam int clk_period    = 100;
    localparam int n_random_runs = 6;
    localparam int total_runs    = n_random_runs + 3;
    localparam int run_cycles    = (vga_pkg::frame_pixels + vga_pkg::h_display) * 4;

    logic                clk;
    logic                rst;
    logic                init_type;
    logic                init_start;
    logic                init_done;
    logic                rd_en;
    vga_pkg::vram_addr_t rd_address;
    vga_pkg::pixel_t     rd_data;
    logic                rd_valid;

    integer          seed = 32'h4195;
    logic [31:0]     rnd;
    logic            check_off;          // read compare off while an init runs
    int              timeout_errors = 0;
    vga_pkg::pixel_t ref_frame [vga_pkg::frame_pixels];

    dla_init_subsys dut (
        .clk        (clk),
        .rst        (rst),
        .init_type  (init_type),
        .init_start (init_start),
        .init_done  (init_done),
        .rd_en      (rd_en),
        .rd_address (rd_address),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    dla_init_checker u_check (
        .clk        (clk),
        .rst        (rst),
        .init_start (init_start),
        .init_done  (init_done),
        .rd_en      (rd_en),
        .rd_address (rd_address),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------------------------------------------------------
    // frame model is a black frame plus the seed of the chosen mode
    // --------------------------------------------------------------------
    task automatic set_model(input logic mode);
        for (int a = 0; a < vga_pkg::frame_pixels; a++)
            ref_frame[a] = dla_pkg::pixel_black;
        if (mode == dla_pkg::init_forest) begin
            for (int c = 0; c < vga_pkg::h_display; c++)
                ref_frame[(vga_pkg::v_display - 1) * vga_pkg::h_display + c] =
                    dla_pkg::pixel_white;
        end
        else begin
            ref_frame[(vga_pkg::v_display / 2) * vga_pkg::h_display
                      + vga_pkg::h_display / 2] = dla_pkg::pixel_white;
        end
    endtask

    // start an init with optional random reads and wait for init_done
    task automatic run_init(input logic mode, input logic busy);
        int   cycles;
        logic got;
        set_model(mode);
        check_off  = 1'b1;
        init_type  = mode;
        init_start = 1'b1;
        @(posedge clk);
        #1;
        init_start = 1'b0;
        cycles     = 0;
        got        = 1'b0;
        while (!got && cycles < run_cycles) begin
            rnd        = $random(seed);
            rd_en      = busy & rnd[0];   // about half the cycles
            rnd        = $random(seed);
            rd_address = vga_pkg::vram_addr_t'(rnd % vga_pkg::frame_pixels);
            @(posedge clk);
            #1;
            got    = init_done;
            cycles = cycles + 1;
        end
        rd_en     = 1'b0;
        check_off = 1'b0;
        if (!got) begin
            timeout_errors = timeout_errors + 1;
            $display("init_done did not arrive within %0d cycles of init_start", run_cycles);
        end
    endtask

    // read every pixel once so the checker can compare the data
    task automatic read_frame();
        for (int a = 0; a < vga_pkg::frame_pixels; a++) begin
            rd_en      = 1'b1;
            rd_address = vga_pkg::vram_addr_t'(a);
            @(posedge clk);
            #1;
        end
        rd_en = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    // --------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------
    initial begin
        rst        = 1'b1;
        init_type  = dla_pkg::init_snowflake;
        init_start = 1'b0;
        rd_en      = 1'b0;
        rd_address = '0;
        check_off  = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        run_init(dla_pkg::init_snowflake, 1'b0);
        read_frame();
        run_init(dla_pkg::init_forest, 1'b0);
        read_frame();
        // reads stall the sweep, the stalled clear must still erase the white row
        run_init(dla_pkg::init_snowflake, 1'b1);
        read_frame();
        for (int r = 0; r < n_random_runs; r++) begin
            rnd = $random(seed);
            run_init(rnd[0], rnd[1]);
            read_frame();
        end

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 u_check.value_errors, u_check.protocol_errors, timeout_errors);
        if (u_check.value_errors + u_check.protocol_errors + timeout_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // watchdog sized for the worst case init plus readback of every run
    initial begin
        repeat (total_runs * (run_cycles + vga_pkg::frame_pixels + 4) + 1000)
            @(posedge clk);
        $display("watchdog timeout, the run did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/dla_init_checker.sv
// --------------------------------------------------------------------
// watches the DLA init subsystem ports, checks read timing and data
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dla_init_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      init_start,
    input  wire                      init_done,
    input  wire                      rd_en,
    input  wire vga_pkg::vram_addr_t rd_address,
    input  wire vga_pkg::pixel_t     rd_data,
    input  wire                      rd_valid
);

    int value_errors    = 0;
    int protocol_errors = 0;
    int inits_open      = 0;   // starts still waiting for init_done
    int open_next;

    logic                rd_pend  = 1'b0;   // read issued last cycle
    logic                rd_check = 1'b0;   // and its data is compared
    vga_pkg::vram_addr_t rd_addr_q;
    vga_pkg::pixel_t     exp_data;

    always @(posedge clk) begin
        if (rst) begin
            rd_pend    <= 1'b0;
            rd_check   <= 1'b0;
            inits_open <= 0;
        end
        else begin
            rd_pend   <= rd_en;
            rd_check  <= rd_en & ~tb_dla_init.check_off;
            rd_addr_q <= rd_address;

            // ----------------------------------------------------------------
            // read port timing and data
            // ----------------------------------------------------------------
            if (rd_pend && !rd_valid) begin
                protocol_errors = protocol_errors + 1;
                $display("rd_valid did not follow rd_en one cycle later, time %0t", $time);
            end
            if (!rd_pend && rd_valid) begin
                protocol_errors = protocol_errors + 1;
                $display("rd_valid was high without a read request, time %0t", $time);
            end
            if (rd_pend && rd_valid && rd_check) begin
                exp_data = tb_dla_init.ref_frame[rd_addr_q];
                if (rd_data !== exp_data) begin
                    value_errors = value_errors + 1;
                    $display("** Error at %0t: pixel %0d read %h, expected %h",
                             $time, rd_addr_q, rd_data, exp_data);
                end
            end

            // every done must pair with an earlier start
            open_next = inits_open;
            if (init_start)
                open_next = open_next + 1;
            if (init_done) begin
                if (inits_open == 0) begin
                    protocol_errors = protocol_errors + 1;
                    $display("init_done pulsed with no init in progress, time %0t", $time);
                end
                else begin
                    open_next = open_next - 1;
                end
            end
            inits_open <= open_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dla_init_subsys.sv
// --------------------------------------------------------------------
// DLA video memory init subsystem, init block feeding the frame memory
// through the write FIFO, with the scan-out read port brought out
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dla_init_subsys (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 init_type,
    input  wire                 init_start,
    output logic                init_done,

    input  wire                 rd_en,
    input  wire vga_pkg::vram_addr_t rd_address,
    output vga_pkg::pixel_t     rd_data,
    output logic                rd_valid
);

    // init block to FIFO
    vga_pkg::vram_addr_t wr_address;
    vga_pkg::pixel_t     wr_data;
    logic                wr_last;
    logic                wr_write;
    logic                wr_waitrequest;

    // FIFO to frame memory
    vga_pkg::vram_addr_t q_address;
    vga_pkg::pixel_t     q_data;
    logic                q_last;
    logic                q_valid;
    logic                q_ready;

    dla_vram_init u_init (
        .clk            (clk),
        .rst            (rst),
        .init_type      (init_type),
        .init_start     (init_start),
        .wr_address     (wr_address),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .wr_write       (wr_write),
        .wr_waitrequest (wr_waitrequest)
    );

    vram_write_fifo #(
        .depth          (dla_pkg::wbuf_depth)
    ) u_wbuf (
        .clk            (clk),
        .rst            (rst),
        .wr_address     (wr_address),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .wr_write       (wr_write),
        .wr_waitrequest (wr_waitrequest),
        .q_address      (q_address),
        .q_data         (q_data),
        .q_last         (q_last),
        .q_valid        (q_valid),
        .q_ready        (q_ready)
    );

    dla_vram u_vram (
        .clk            (clk),
        .rst            (rst),
        .q_address      (q_address),
        .q_data         (q_data),
        .q_last         (q_last),
        .q_valid        (q_valid),
        .q_ready        (q_ready),
        .rd_en          (rd_en),
        .rd_address     (rd_address),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid),
        .init_done      (init_done)
    );

endmodule

`default_nettype wire

//--- verilog/dla_vram.sv
// --------------------------------------------------------------------
// DLA frame memory, single port shared by scan-out reads and buffered
// writes, reads win, init_done pulses once the last seed write lands
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dla_vram (
    input  wire                 clk,
    input  wire                 rst,

    // buffered write entries
    input  wire vga_pkg::vram_addr_t q_address,
    input  wire vga_pkg::pixel_t     q_data,
    input  wire                 q_last,
    input  wire                 q_valid,
    output logic                q_ready,

    // scan-out read port
    input  wire                 rd_en,
    input  wire vga_pkg::vram_addr_t rd_address,
    output vga_pkg::pixel_t     rd_data,
    output logic                rd_valid,

    output logic                init_done
);

    // ------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------

    vga_pkg::pixel_t mem [vga_pkg::frame_pixels];

    logic commit;   // buffered entry written this cycle

    // the port is busy whenever a read is requested
    assign q_ready = ~rd_en;
    assign commit  = q_valid & q_ready;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_address];
        end
        else if (commit) begin
            mem[q_address] <= q_data;
        end
    end

    // ------------------------------------------------------------------
    // status
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            init_done <= 1'b0;
        end
        else begin
            rd_valid  <= rd_en;             // data follows one cycle later
            init_done <= commit & q_last;   // final seed pixel is in memory
        end
    end

endmodule

`default_nettype wire

//--- verilog/vram_write_fifo.sv
// --------------------------------------------------------------------
// small write buffer between the init block and the frame memory
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module vram_write_fifo #(
    parameter int depth = dla_pkg::wbuf_depth   // power of two, at least 2
) (
    input  wire                 clk,
    input  wire                 rst,

    // push side, waitrequest while full
    input  wire vga_pkg::vram_addr_t wr_address,
    input  wire vga_pkg::pixel_t     wr_data,
    input  wire                 wr_last,
    input  wire                 wr_write,
    output logic                wr_waitrequest,

    // pop side, valid/ready
    output vga_pkg::vram_addr_t q_address,
    output vga_pkg::pixel_t     q_data,
    output logic                q_last,
    output logic                q_valid,
    input  wire                 q_ready
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    vga_pkg::vram_addr_t addr_mem [depth];
    vga_pkg::pixel_t     data_mem [depth];
    logic                last_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // occupancy

    logic push;
    logic pop;

    assign wr_waitrequest = (count == cnt_w'(depth));
    assign q_valid        = (count != '0);
    assign push           = wr_write & ~wr_waitrequest;
    assign pop            = q_valid & q_ready;

    // head of queue
    assign q_address = addr_mem[rd_ptr];
    assign q_data    = data_mem[rd_ptr];
    assign q_last    = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= wr_address;
            data_mem[wr_ptr] <= wr_data;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/dla_vram_init.sv
// --------------------------------------------------------------------
// DLA frame init, clears the frame to black and then writes the seed
// writes leave on a waitrequest handshake, last write carries wr_last
// --------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dla_vram_init (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 init_type,   // 0 snowflake, 1 forest
    input  wire                 init_start,

    // write request side
    output vga_pkg::vram_addr_t wr_address,
    output vga_pkg::pixel_t     wr_data,
    output logic                wr_last,
    output logic                wr_write,
    input  wire                 wr_waitrequest
);

    // ------------------------------------------------------------------
    // declarations
    // ------------------------------------------------------------------

    localparam int s_idle  = 0;
    localparam int s_clear = 1;   // sweep frame with black
    localparam int s_seed  = 2;   // place the seed pixels
    localparam int s_done  = 3;

    localparam int col_w = $clog2(vga_pkg::h_display);

    logic [3:0]          state;
    logic [3:0]          state_next;

    vga_pkg::vram_addr_t addr;   // clear sweep position
    logic [col_w-1:0]    col;    // bottom row column, forest only
    logic                mode;   // init_type latched at start

    logic accept;
    logic clear_end;
    logic seed_end;

    // ------------------------------------------------------------------
    // handshake and end conditions
    // ------------------------------------------------------------------

    assign accept    = wr_write & ~wr_waitrequest;
    assign clear_end = (addr == vga_pkg::vram_addr_t'(vga_pkg::frame_pixels - 1));
    assign seed_end  = (mode == dla_pkg::init_snowflake) ||
                       (col == col_w'(vga_pkg::h_display - 1));

    // write request outputs, decoded from state
    always_comb begin
        wr_write = state[s_clear] | state[s_seed];
        wr_last  = state[s_seed] & seed_end;
        if (state[s_seed]) begin
            wr_data = dla_pkg::pixel_white;
            if (mode == dla_pkg::init_forest)
                wr_address = dla_pkg::seed_row_addr + vga_pkg::vram_addr_t'(col);
            else
                wr_address = dla_pkg::seed_centre_addr;
        end
        else begin
            wr_data    = dla_pkg::pixel_black;
            wr_address = addr;
        end
    end

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------

    always_comb begin
        state_next = '0;
        case (1'b1)
            state[s_idle]: begin
                if (init_start) state_next[s_clear] = 1'b1;
                else            state_next[s_idle]  = 1'b1;
            end
            state[s_clear]: begin
                if (accept && clear_end) state_next[s_seed]  = 1'b1;
                else                     state_next[s_clear] = 1'b1;
            end
            state[s_seed]: begin
                if (accept && seed_end) state_next[s_done] = 1'b1;
                else                    state_next[s_seed] = 1'b1;
            end
            state[s_done]: state_next[s_idle] = 1'b1;
            default:       state_next[s_idle] = 1'b1;   // recover from bad encoding
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 4'b0001;
            addr  <= '0;
            col   <= '0;
            mode  <= dla_pkg::init_snowflake;
        end
        else begin
            state <= state_next;
            if (state[s_idle] && init_start) begin
                mode <= init_type;
                addr <= '0;
                col  <= '0;
            end
            else if (accept && state[s_clear]) begin
                addr <= addr + 1'b1;
            end
            else if (accept && state[s_seed]) begin
                col <= col + 1'b1;   // only meaningful in forest mode
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dla_pkg.sv
// --------------------------------------------------------------------
// DLA init modes, pixel colours and write buffer sizing
// --------------------------------------------------------------------
`default_nettype none

package dla_pkg;

    // init_type encoding
    localparam logic init_snowflake = 1'b0;   // single centre seed
    localparam logic init_forest    = 1'b1;   // white bottom row

    localparam vga_pkg::pixel_t pixel_black = '0;
    localparam vga_pkg::pixel_t pixel_white = '1;

    // seed positions
    localparam vga_pkg::vram_addr_t seed_centre_addr = vga_pkg::vram_addr_t'(
        (vga_pkg::v_display / 2) * vga_pkg::h_display + vga_pkg::h_display / 2);
    localparam vga_pkg::vram_addr_t seed_row_addr = vga_pkg::vram_addr_t'(
        (vga_pkg::v_display - 1) * vga_pkg::h_display);

    localparam int wbuf_depth = 4;   // entries between init and vram

endpackage

`default_nettype wire

//--- verilog/vga_pkg.sv
// --------------------------------------------------------------------
// frame geometry and video memory sizes shared by the DLA display blocks
// --------------------------------------------------------------------
`default_nettype none

package vga_pkg;

    localparam int h_display    = 32;   // pixels per line
    localparam int v_display    = 24;   // lines per frame
    localparam int frame_pixels = h_display * v_display;

    // row-major addressing, addr = line * h_display + column
    localparam int vram_aw = 10;
    localparam int vram_dw = 16;

    typedef logic [vram_aw-1:0] vram_addr_t;
    typedef logic [vram_dw-1:0] pixel_t;

endpackage

`default_nettype wire
